//--- Makefile
# Verilator build and run of the card bus testbench

sim:
	verilator --binary --timing --assert --top-module card_bus_tb -f build.f -Mdir obj_dir -o card_bus_sim
	./obj_dir/card_bus_sim +verilator+error+limit+100 | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- build.f
design/bus_pkg.sv
design/reg_ar.sv
design/mbu.sv
design/constant_store.sv
design/databus.sv
design/card_bus.sv
test/card_bus_properties.sv
test/card_bus_tb.sv

//--- design/bus_pkg.sv
package bus_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////

   localparam int ADDR_W   = 24;                // Address bus
   localparam int WORD_W   = 16;                // Processor bus and data bus
   localparam int UADDR_W  = 5;                 // Microcode read and write fields
   localparam int ACTION_W = 4;                 // Microcode action field
   localparam int BANK_N   = 8;                 // MBU bank registers
   localparam int BANK_W   = $clog2(BANK_N);    // Bank index
   localparam int AEXT_W   = ADDR_W - WORD_W;   // Address extension byte
   localparam int IO_W     = 10;                // Decoded low I/O space
   localparam int CONST_N  = 8;                 // Words in the constant store
   localparam int CONST_W  = $clog2(CONST_N);   // Constant index

   ////////////////////////////////////////
   // Microcode address codes
   ////////////////////////////////////////

   // Write side, AR loads
   localparam logic [UADDR_W-1:0] WADDR_AR_IDX = 5'd7;    // Bank from IR[2:0]
   localparam logic [UADDR_W-1:0] WADDR_AR_MB0 = 5'd8;    // MB0..MB7 at 8..15

   // Read side
   localparam logic [UADDR_W-1:0] RADDR_DR     = 5'd2;    // Data bus to IBus
   localparam logic [UADDR_W-1:0] RADDR_CONST0 = 5'd24;   // Constants at 24..31

   // System I/O port of MB0, banks follow on consecutive ports
   localparam logic [AEXT_W-1:0] MBU_PORT_BASE = 8'h08;

   // Constant store contents, index 0 is the rightmost word
   localparam logic [CONST_N-1:0][WORD_W-1:0] CONST_TABLE = {
      16'hFFFF,   // 7
      16'hFFFE,   // 6
      16'h8000,   // 5
      16'h0008,   // 4
      16'h0004,   // 3
      16'h0002,   // 2
      16'h0001,   // 1
      16'h0000    // 0
   };

   ////////////////////////////////////////
   // Bus bundles
   ////////////////////////////////////////

   typedef struct packed {
      logic [UADDR_W-1:0]  raddr;    // IBus read address
      logic [UADDR_W-1:0]  waddr;    // IBus write address
      logic [ACTION_W-1:0] action;   // Action code
      logic                nmem;     // Memory space cycle
      logic                nio;      // I/O space cycle
      logic                nr;       // Read request
      logic                nwen;     // Write enable from control unit
   } uctl_t;

   typedef struct packed {
      logic [BANK_W-1:0] ir;         // IR[2:0] from control unit
      logic              nir_idx;    // Use IR to pick the bank
      logic              nfparh;     // Front panel wants AR[23:16]
   } cport_t;

   typedef struct packed {
      logic nsysdev;                 // I/O 000-0FF
      logic niodev1xx;               // I/O 100-1FF
      logic niodev2xx;               // I/O 200-2FF
      logic niodev3xx;               // I/O 300-3FF
   } iodec_t;

   typedef struct packed {
      logic              en;         // Something drives the IBus
      logic [WORD_W-1:0] data;
   } ibus_ret_t;

   typedef struct packed {
      logic [WORD_W-1:0] data;       // Outgoing write data
      logic              nw;         // Write strobe
   } dbus_t;

   // Bus cycle sequencer states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACTIVE,
      ST_DONE
   } dbus_state_t;

endpackage

//--- design/card_bus.sv
`timescale 1ns/10ps

module card_bus import bus_pkg::*; (
   input  logic              clk1,
   input  logic              arst_n,
   input  uctl_t             uctl,       // Microcode fields
   input  cport_t            cport,      // Unbussed backplane pins
   input  logic [WORD_W-1:0] ibus_in,    // Processor bus toward the card
   input  logic [WORD_W-1:0] db_in,      // Data bus toward the card
   input  logic              nws,        // Wait state request
   input  logic              nhalt,      // Halt
   output logic [ADDR_W-1:0] ab,         // 24-bit address bus
   output iodec_t            iodec,      // I/O device selects
   output dbus_t             dbus,       // Data bus from the card
   output logic              nwaiting,   // Wait state acknowledge
   output ibus_ret_t         ibus_ret,   // Processor bus from the card
   output logic [AEXT_W-1:0] fpd         // Front panel byte
);

   logic [AEXT_W-1:0] aext;        // MBU to AR[23:16]
   logic              nwrite_ar;   // MBU to AR load
   ibus_ret_t         const_ret;   // Constant store to databus

   ////////////////////////////////////////
   // Address register
   ////////////////////////////////////////

   reg_ar reg_ar (
      .clk1      (clk1),
      .arst_n    (arst_n),
      .nio       (uctl.nio),
      .nfparh    (cport.nfparh),
      .ibus_in   (ibus_in),
      .aext      (aext),
      .nwrite_ar (nwrite_ar),
      .ab        (ab),
      .iodec     (iodec),
      .fpd       (fpd)
   );

   ////////////////////////////////////////
   // Memory banking unit
   ////////////////////////////////////////

   mbu mbu (
      .clk1      (clk1),
      .arst_n    (arst_n),
      .waddr     (uctl.waddr),
      .ir        (cport.ir),
      .nir_idx   (cport.nir_idx),
      .ibus_in   (ibus_in[AEXT_W-1:0]),   // Banks are one byte
      .ab_low    (ab[AEXT_W-1:0]),
      .nsysdev   (iodec.nsysdev),
      .nw        (dbus.nw),
      .aext      (aext),
      .nwrite_ar (nwrite_ar)
   );

   ////////////////////////////////////////
   // Constant store
   ////////////////////////////////////////

   constant_store constant_store (
      .raddr     (uctl.raddr),
      .const_ret (const_ret)
   );

   ////////////////////////////////////////
   // Data bus unit
   ////////////////////////////////////////

   databus databus (
      .clk1      (clk1),
      .arst_n    (arst_n),
      .nmem      (uctl.nmem),
      .nio       (uctl.nio),
      .nr        (uctl.nr),
      .nwen      (uctl.nwen),
      .raddr     (uctl.raddr),
      .nhalt     (nhalt),
      .nws       (nws),
      .ibus_in   (ibus_in),
      .db_in     (db_in),
      .const_ret (const_ret),
      .dbus      (dbus),
      .nwaiting  (nwaiting),
      .ibus_ret  (ibus_ret)
   );

endmodule

//--- design/constant_store.sv
`timescale 1ns/10ps

module constant_store import bus_pkg::*; (
   input  logic [UADDR_W-1:0] raddr,       // Microcode read address
   output ibus_ret_t          const_ret    // Constant onto the IBus
);

   logic [UADDR_W-1:0] c_off;   // Offset into the table
   logic               c_hit;   // Read address in the constant range

   ////////////////////////////////////////
   // Constant lookup
   ////////////////////////////////////////

   // Addresses below the base wrap to a large offset and miss
   assign c_off = raddr - RADDR_CONST0;
   assign c_hit = c_off < UADDR_W'(CONST_N);

   always_comb begin
      const_ret.en   = c_hit;
      const_ret.data = '0;   // Quiet when not selected
      if (c_hit) begin
         const_ret.data = CONST_TABLE[c_off[CONST_W-1:0]];
      end
   end

endmodule

//--- design/databus.sv
`timescale 1ns/10ps

module databus import bus_pkg::*; (
   input  logic               clk1,
   input  logic               arst_n,
   input  logic               nmem,        // Memory cycle request
   input  logic               nio,         // I/O cycle request
   input  logic               nr,          // Read
   input  logic               nwen,        // Write enable
   input  logic [UADDR_W-1:0] raddr,       // Microcode read address
   input  logic               nhalt,       // Halt blocks new cycles
   input  logic               nws,         // Wait state from the device
   input  logic [WORD_W-1:0]  ibus_in,     // Write data source
   input  logic [WORD_W-1:0]  db_in,       // Read data from the bus
   input  ibus_ret_t          const_ret,   // Constant store output
   output dbus_t              dbus,        // Outgoing data and strobe
   output logic               nwaiting,    // Wait state acknowledge
   output ibus_ret_t          ibus_ret     // Merged IBus return
);

   dbus_state_t       state;       // Sequencer state
   logic              nw_q;        // Write strobe
   logic [WORD_W-1:0] wdata_q;     // Latched write data
   logic              cyc_req;     // Microcode wants a bus cycle
   logic              cyc_start;   // Cycle begins this clock
   logic              rd_dr;       // Data bus read onto the IBus

   ////////////////////////////////////////
   // Cycle sequencer
   ////////////////////////////////////////

   assign cyc_req   = (!nmem || !nio) && (!nr || !nwen);
   assign cyc_start = cyc_req && nhalt && (state == ST_IDLE);

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
         nw_q  <= 1'b1;
      end else begin
         case (state)
            ST_IDLE: begin
               if (cyc_start) begin
                  state <= ST_ACTIVE;
                  nw_q  <= nwen;          // Strobe only for writes
               end
            end
            ST_ACTIVE: begin
               if (nws) begin             // No wait state, finish
                  state <= ST_DONE;
                  nw_q  <= 1'b1;
               end
            end
            ST_DONE: begin
               if (nmem && nio) begin     // Re-arm once request drops
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Write data held for the whole strobe
   always_ff @(posedge clk1) begin
      if (cyc_start && !nwen) begin
         wdata_q <= ibus_in;
      end
   end

   assign dbus.data = wdata_q;
   assign dbus.nw   = nw_q;

   // Acknowledge wait states only inside a cycle
   assign nwaiting = !((state == ST_ACTIVE) && !nws);

   ////////////////////////////////////////
   // IBus return
   ////////////////////////////////////////

   assign rd_dr = (raddr == RADDR_DR) && !nr;

   always_comb begin
      ibus_ret = const_ret;   // Constants unless DR is read
      if (rd_dr) begin
         ibus_ret.en   = 1'b1;
         ibus_ret.data = db_in;
      end
   end

endmodule

//--- design/mbu.sv
`timescale 1ns/10ps

module mbu import bus_pkg::*; (
   input  logic               clk1,
   input  logic               arst_n,
   input  logic [UADDR_W-1:0] waddr,       // Microcode write address
   input  logic [BANK_W-1:0]  ir,          // IR[2:0]
   input  logic               nir_idx,     // Index the bank by IR
   input  logic [AEXT_W-1:0]  ibus_in,     // IBus low byte
   input  logic [AEXT_W-1:0]  ab_low,      // AB[7:0]
   input  logic               nsysdev,     // System I/O select
   input  logic               nw,          // Bus write strobe
   output logic [AEXT_W-1:0]  aext,        // Selected bank byte
   output logic               nwrite_ar    // AR load strobe
);

   logic [AEXT_W-1:0]  bank_q [BANK_N];   // MB0..MB7

   logic               port_hit;          // AB[7:3] on the MBU ports
   logic               bank_we;           // Bank register write
   logic [BANK_W-1:0]  bank_wsel;         // Bank being written

   logic [UADDR_W-1:0] mb_off;            // Offset from WADDR_AR_MB0
   logic               sel_mb;            // Explicit MBn write address
   logic               sel_idx;           // IR indexed write address
   logic [BANK_W-1:0]  bank_sel;          // Bank feeding AEXT

   ////////////////////////////////////////
   // Bank register writes
   ////////////////////////////////////////

   // Ports MBU_PORT_BASE .. +7 of the system device page
   assign port_hit  = ab_low[AEXT_W-1:BANK_W] == MBU_PORT_BASE[AEXT_W-1:BANK_W];
   assign bank_we   = !nsysdev && !nw && port_hit;
   assign bank_wsel = ab_low[BANK_W-1:0];   // Port offset is the index

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < BANK_N; i++) begin
            bank_q[i] <= '0;   // All banks start at 0
         end
      end else if (bank_we) begin
         bank_q[bank_wsel] <= ibus_in;
      end
   end

   ////////////////////////////////////////
   // Bank selection
   ////////////////////////////////////////

   assign mb_off  = waddr - WADDR_AR_MB0;              // Wraps below MB0
   assign sel_mb  = mb_off < UADDR_W'(BANK_N);
   assign sel_idx = waddr == WADDR_AR_IDX;

   always_comb begin
      bank_sel = '0;   // MB0 by default
      if (sel_mb) begin
         bank_sel = mb_off[BANK_W-1:0];
      end else if (sel_idx && !nir_idx) begin
         bank_sel = ir;   // Indexed by the instruction
      end
   end

   // AR is written by any of the nine codes
   assign nwrite_ar = !(sel_mb || sel_idx);

   assign aext = bank_q[bank_sel];

endmodule

//--- design/reg_ar.sv
`timescale 1ns/10ps

module reg_ar import bus_pkg::*; (
   input  logic              clk1,
   input  logic              arst_n,
   input  logic              nio,         // I/O space cycle
   input  logic              nfparh,      // Front panel high byte request
   input  logic [WORD_W-1:0] ibus_in,     // Low word source
   input  logic [AEXT_W-1:0] aext,        // Bank byte from MBU
   input  logic              nwrite_ar,   // Load strobe from MBU
   output logic [ADDR_W-1:0] ab,          // Address bus
   output iodec_t            iodec,       // Device selects
   output logic [AEXT_W-1:0] fpd          // Front panel byte
);

   logic [ADDR_W-1:0] ar_q;      // The address register
   logic              io_low;    // I/O cycle inside the low 1K
   logic [1:0]        io_page;   // Which 256-port page

   ////////////////////////////////////////
   // Address register
   ////////////////////////////////////////

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         ar_q <= '0;
      end else if (!nwrite_ar) begin
         ar_q <= {aext, ibus_in};   // Bank byte on top of IBus word
      end
   end

   assign ab = ar_q;   // AR drives AB directly

   ////////////////////////////////////////
   // I/O space decoder
   ////////////////////////////////////////

   assign io_low  = !nio && (ab[ADDR_W-1:IO_W] == '0);   // Only ports below 400h
   assign io_page = ab[IO_W-1:IO_W-2];                    // AB[9:8]

   always_comb begin
      iodec = '1;   // All deselected
      if (io_low) begin
         case (io_page)
            2'd0: begin
               iodec.nsysdev = 1'b0;     // System devices, MBU lives here
            end
            2'd1: begin
               iodec.niodev1xx = 1'b0;
            end
            2'd2: begin
               iodec.niodev2xx = 1'b0;
            end
            default: begin
               iodec.niodev3xx = 1'b0;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Front panel
   ////////////////////////////////////////

   // Low byte unless the panel asks for the bank byte
   assign fpd = nfparh ? ab[AEXT_W-1:0] : ab[ADDR_W-1:WORD_W];

endmodule

//--- test/card_bus_properties.sv
`timescale 1ns/10ps

module card_bus_properties import bus_pkg::*; (
   input logic               clk1,
   input logic               arst_n,
   input dbus_state_t        state,       // Sequencer state
   input dbus_t              dbus,        // Data bus and write strobe
   input logic               nwaiting,    // Wait state acknowledge
   input logic               nr,          // Read request
   input logic [UADDR_W-1:0] raddr,       // Microcode read address
   input ibus_ret_t          ibus_ret     // Merged IBus return
);

   int sva_errors = 0;   // Failed assertion count

   ////////////////////////////////////////
   // Strobe rules

   idle_nw_high: assert property (@(posedge clk1) disable iff (!arst_n)
      (state == ST_IDLE) |-> dbus.nw)
      else begin
         $error("write strobe low while the sequencer is idle");
         sva_errors++;
      end

   // Wait state holds the strobe and the data
   wait_holds_write: assert property (@(posedge clk1) disable iff (!arst_n)
      (!nwaiting && !dbus.nw) |=> (!dbus.nw && $stable(dbus.data)))
      else begin
         $error("write strobe or data changed during a wait state");
         sva_errors++;
      end

   // Nothing drives the IBus unless DR or a constant address is read
   ret_en_needs_source: assert property (@(posedge clk1) disable iff (!arst_n)
      ibus_ret.en |-> (((raddr == RADDR_DR) && !nr) || (raddr >= RADDR_CONST0)))
      else begin
         $error("ibus_ret.en high without a matching read address");
         sva_errors++;
      end

endmodule

bind databus card_bus_properties props (
   .clk1      (clk1),
   .arst_n    (arst_n),
   .state     (state),
   .dbus      (dbus),
   .nwaiting  (nwaiting),
   .nr        (nr),
   .raddr     (raddr),
   .ibus_ret  (ibus_ret)
);

//--- test/card_bus_tb.sv
`timescale 1ns/10ps

module card_bus_tb import bus_pkg::*; ();

   localparam int CLK_PERIOD = 10;    // ns
   localparam int N_TESTS    = 6;
   localparam int TEST_CYC   = 200;   // Cycle budget per test

   logic              clk1;
   logic              arst_n;
   uctl_t             uctl;
   cport_t            cport;
   logic [WORD_W-1:0] ibus_in;
   logic [WORD_W-1:0] db_in;
   logic              nws;
   logic              nhalt;
   logic [ADDR_W-1:0] ab;
   iodec_t            iodec;
   dbus_t             dbus;
   logic              nwaiting;
   ibus_ret_t         ibus_ret;
   logic [AEXT_W-1:0] fpd;

   int value_errors;   // Wrong values
   int other_errors;   // Timeouts and missing strobes

   card_bus UUT (
      .clk1     (clk1),
      .arst_n   (arst_n),
      .uctl     (uctl),
      .cport    (cport),
      .ibus_in  (ibus_in),
      .db_in    (db_in),
      .nws      (nws),
      .nhalt    (nhalt),
      .ab       (ab),
      .iodec    (iodec),
      .dbus     (dbus),
      .nwaiting (nwaiting),
      .ibus_ret (ibus_ret),
      .fpd      (fpd)
   );

   always #(CLK_PERIOD / 2) clk1 = ~clk1;

   ////////////////////////////////////////
   // Timing and bus helpers

   task automatic step();   // Next drive point
      @(posedge clk1);
      #1;
   endtask

   task automatic settle();   // Mid cycle, outputs stable
      @(negedge clk1);
   endtask

   task automatic clear_uctl();
      uctl.raddr  = '0;   // Neither DR nor a constant
      uctl.waddr  = '0;   // No AR load
      uctl.action = '0;
      uctl.nmem   = 1'b1;
      uctl.nio    = 1'b1;
      uctl.nr     = 1'b1;
      uctl.nwen   = 1'b1;
   endtask

   task automatic apply_reset();
      step();
      arst_n = 1'b0;
      repeat (5) @(posedge clk1);
      #1;
      arst_n = 1'b1;
   endtask

   task automatic load_ar(input logic [UADDR_W-1:0] code, input logic [WORD_W-1:0] word);
      step();
      uctl.waddr = code;
      ibus_in    = word;
      step();              // AR takes the word here
      uctl.waddr = '0;
   endtask

   task automatic wait_nw(input logic level);
      int n;
      n = 0;
      while (dbus.nw !== level && n < 8) begin
         step();
         n++;
      end
      if (dbus.nw !== level) begin
         other_errors++;
         $display("Write strobe never went to %b within 8 cycles, at %0t", level, $time);
      end
   endtask

   task automatic io_write(input logic [WORD_W-1:0] data);
      step();
      uctl.nio  = 1'b0;
      uctl.nwen = 1'b0;
      ibus_in   = data;
      wait_nw(1'b0);
      wait_nw(1'b1);       // Bank loads on this edge when addressed
      uctl.nio  = 1'b1;
      uctl.nwen = 1'b1;
      step();              // Back to idle
   endtask

   ////////////////////////////////////////
   // Expected values

   function automatic logic [WORD_W-1:0] const_word(input int i);
      case (i)
         0: return 16'h0000;
         1: return 16'h0001;
         2: return 16'h0002;
         3: return 16'h0004;
         4: return 16'h0008;
         5: return 16'h8000;
         6: return 16'hFFFE;
         default: return 16'hFFFF;
      endcase
   endfunction

   function automatic iodec_t expect_iodec(input logic [ADDR_W-1:0] addr, input logic nio);
      iodec_t d;
      logic   low_io;
      low_io      = (nio == 1'b0) && (addr[23:10] == 14'd0);
      d.nsysdev   = !(low_io && addr[9:8] == 2'd0);
      d.niodev1xx = !(low_io && addr[9:8] == 2'd1);
      d.niodev2xx = !(low_io && addr[9:8] == 2'd2);
      d.niodev3xx = !(low_io && addr[9:8] == 2'd3);
      return d;
   endfunction

   function automatic logic [AEXT_W-1:0] expect_fpd(input logic [ADDR_W-1:0] addr,
                                                    input logic nfparh);
      return nfparh ? addr[7:0] : addr[23:16];
   endfunction

   function automatic ibus_ret_t make_ret(input logic en, input logic [WORD_W-1:0] data);
      ibus_ret_t r;
      r.en   = en;
      r.data = data;
      return r;
   endfunction

   ////////////////////////////////////////
   // Compare tasks

   task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
      if (got !== exp) begin
         value_errors++;
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                             input logic [ADDR_W-1:0] exp);
      if (got !== exp) begin
         value_errors++;
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_iodec(input string name, input iodec_t got, input iodec_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   // Data only matters while the return is enabled
   task automatic check_ret(input string name, input ibus_ret_t got, input ibus_ret_t exp);
      if (got.en !== exp.en || (exp.en === 1'b1 && got.data !== exp.data)) begin
         value_errors++;
         $display("error at %0t: %s is %b/%h, expected %b/%h", $time, name,
                  got.en, got.data, exp.en, exp.data);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         value_errors++;
         $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   ////////////////////////////////////////
   // Tests

   task automatic t_reset();
      logic [WORD_W-1:0] word;
      apply_reset();
      settle();
      check_addr("ab", ab, '0);
      check_bit("dbus.nw", dbus.nw, 1'b1);
      check_bit("nwaiting", nwaiting, 1'b1);
      check_ret("ibus_ret", ibus_ret, make_ret(1'b0, '0));
      check_iodec("iodec", iodec, iodec_t'(4'b1111));
      for (int n = 0; n < BANK_N; n++) begin   // Every bank reads back zero
         word = 16'($urandom);
         load_ar(WADDR_AR_MB0 + UADDR_W'(n), word);
         settle();
         check_addr("ab", ab, {8'h00, word});
      end
   endtask

   task automatic t_constants();
      for (int i = 0; i < 8; i++) begin
         step();
         uctl.raddr = RADDR_CONST0 + UADDR_W'(i);
         settle();
         check_ret("ibus_ret", ibus_ret, make_ret(1'b1, const_word(i)));
      end
      step();
      uctl.raddr = RADDR_CONST0 - 5'd1;   // Just below the range
      settle();
      check_ret("ibus_ret", ibus_ret, make_ret(1'b0, '0));
      step();
      uctl.raddr = RADDR_DR;              // DR without a read
      settle();
      check_ret("ibus_ret", ibus_ret, make_ret(1'b0, '0));
      step();
      uctl.raddr = '0;
   endtask

   task automatic t_ar_load();
      logic [AEXT_W-1:0] hi;
      logic [WORD_W-1:0] word;
      logic [ADDR_W-1:0] exp_ab;
      hi = 8'($urandom) | 8'h01;                             // Nonzero bank byte
      load_ar(WADDR_AR_MB0, {8'h00, MBU_PORT_BASE + 8'd3});   // Port of MB3
      io_write({8'h00, hi});
      for (int c = 0; c < 6; c++) begin
         case (c)
            0: word = 16'h0042;
            1: word = 16'h0155;
            2: word = 16'h02AA;
            3: word = 16'h03F0;
            default: word = 16'h0400;
         endcase
         load_ar((c == 5) ? WADDR_AR_MB0 + 5'd3 : WADDR_AR_MB0, word);
         exp_ab = {((c == 5) ? hi : 8'h00), word};
         settle();
         check_addr("ab", ab, exp_ab);
         for (int io = 0; io < 2; io++) begin
            for (int fp = 0; fp < 2; fp++) begin
               step();
               uctl.nio     = 1'(io);
               cport.nfparh = 1'(fp);
               settle();
               check_iodec("iodec", iodec, expect_iodec(exp_ab, uctl.nio));
               check_word("fpd", {8'h00, fpd}, {8'h00, expect_fpd(exp_ab, cport.nfparh)});
            end
         end
         step();
         uctl.nio     = 1'b1;
         cport.nfparh = 1'b1;
      end
   endtask

   task automatic t_bank_write();
      logic [AEXT_W-1:0] bank_val [BANK_N];   // Model of MB0..MB7
      logic [WORD_W-1:0] word;
      apply_reset();
      for (int n = BANK_N - 1; n >= 0; n--) begin   // MB0 last keeps AR in page 0
         bank_val[BANK_W'(n)] = 8'($urandom);
         load_ar(WADDR_AR_MB0, {8'h00, MBU_PORT_BASE + 8'(n)});
         io_write({8'($urandom), bank_val[BANK_W'(n)]});   // High byte ignored
      end
      for (int n = 0; n < BANK_N; n++) begin
         word = 16'($urandom);
         load_ar(WADDR_AR_MB0 + UADDR_W'(n), word);
         settle();
         check_addr("ab", ab, {bank_val[BANK_W'(n)], word});
      end
      for (int n = 0; n < BANK_N; n++) begin   // Bank picked by IR
         word = 16'($urandom);
         step();
         cport.nir_idx = 1'b0;
         cport.ir      = BANK_W'(n);
         load_ar(WADDR_AR_IDX, word);
         settle();
         check_addr("ab", ab, {bank_val[BANK_W'(n)], word});
      end
      word = 16'($urandom);
      step();
      cport.nir_idx = 1'b1;                    // Index off, MB0
      cport.ir      = 3'd5;
      load_ar(WADDR_AR_IDX, word);
      settle();
      check_addr("ab", ab, {bank_val[0], word});
   endtask

   task automatic t_write_wait();
      logic [WORD_W-1:0] data;
      int                width;
      int                left;
      for (int k = 0; k < 4; k++) begin
         data = 16'($urandom);
         step();
         uctl.nmem = 1'b0;
         uctl.nwen = 1'b0;
         ibus_in   = data;
         step();                                  // Cycle starts
         ibus_in = ~data;                         // Latched copy must hold
         width   = 0;
         left    = k;
         while (dbus.nw === 1'b0 && width < 10) begin
            nws = (left > 0) ? 1'b0 : 1'b1;
            settle();
            check_bit("nwaiting", nwaiting, nws);
            check_word("dbus.data", dbus.data, data);
            step();
            width++;
            if (left > 0) begin
               left--;
            end
         end
         check_word("nw low cycles", 16'(width), 16'(k + 1));
         for (int c = 0; c < 3; c++) begin        // Request still held
            nws = (c == 1) ? 1'b0 : 1'b1;         // Stray wait outside a cycle
            settle();
            check_bit("dbus.nw", dbus.nw, 1'b1);
            check_bit("nwaiting", nwaiting, 1'b1);
            step();
         end
         nws       = 1'b1;
         uctl.nmem = 1'b1;
         uctl.nwen = 1'b1;
      end
      step();
      nhalt     = 1'b0;                           // Halt blocks the start
      uctl.nmem = 1'b0;
      uctl.nwen = 1'b0;
      repeat (4) begin
         settle();
         check_bit("dbus.nw", dbus.nw, 1'b1);
         step();
      end
      nhalt = 1'b1;
      wait_nw(1'b0);
      wait_nw(1'b1);
      uctl.nmem = 1'b1;
      uctl.nwen = 1'b1;
   endtask

   task automatic t_read_return();
      logic [WORD_W-1:0] word;
      step();
      uctl.raddr = RADDR_DR;
      uctl.nr    = 1'b0;
      uctl.nmem  = 1'b0;
      nws        = 1'b0;             // Device waits from the start
      step();                        // Read cycle starts
      for (int i = 0; i < 6; i++) begin
         word  = 16'($urandom);
         db_in = word;
         nws   = (i < 3) ? 1'b0 : 1'b1;
         settle();
         check_ret("ibus_ret", ibus_ret, make_ret(1'b1, word));
         check_bit("nwaiting", nwaiting, nws);
         step();
      end
      uctl.nmem = 1'b1;
      uctl.nr   = 1'b1;              // DR no longer read
      settle();
      check_ret("ibus_ret", ibus_ret, make_ret(1'b0, '0));
      step();
      uctl.raddr = '0;
   endtask

   ////////////////////////////////////////
   // Main sequence and watchdog

   initial begin
      clk1          = 1'b0;
      arst_n        = 1'b0;
      clear_uctl();
      cport.ir      = '0;
      cport.nir_idx = 1'b1;
      cport.nfparh  = 1'b1;
      ibus_in       = '0;
      db_in         = '0;
      nws           = 1'b1;
      nhalt         = 1'b1;
      value_errors  = 0;
      other_errors  = 0;
      void'($urandom(6924));
      t_reset();
      t_constants();
      t_ar_load();
      t_bank_write();
      t_write_wait();
      t_read_return();
      step();
      $display("Errors: %0d value, %0d protocol, %0d assertion",
               value_errors, other_errors, UUT.databus.props.sva_errors);
      if (value_errors + other_errors + UUT.databus.props.sva_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(N_TESTS * TEST_CYC * CLK_PERIOD);
      $display("Watchdog expired at %0t before the tests finished", $time);
      $display("TEST FAILED");
      $finish;
   end

endmodule
